/* source/color_map_cfg.svh */
// colour mapper widths, transparency key and handshake timing constants
`ifndef COLOR_MAP_CFG_SVH
`define COLOR_MAP_CFG_SVH

// screen column width
`define CM_X_W 10

// sprite read address, wide enough for the barrier tiles
`define CM_ADDR_W 11

// one colour channel
`define CM_CHAN_W 8

// sprite pixels of this colour let the background through
`define CM_KEY 24'h00FFCC

// blue level of the background at column 0
`define CM_BG_BASE 8'h7F

// req sampled to ack raised, in clock edges
`define CM_RESOLVE_LAT 3

`endif

/* source/color_map_pkg.sv */
// colour mapper types, sprite image identifiers and the pixel colour word
`include "color_map_cfg.svh"

package color_map_pkg;

    // frames of one character form are kept in still, jump, walk1..3 order
    typedef enum logic [4:0] {
        char_still     = 5'd0,
        char_jump      = 5'd1,
        char_walk1     = 5'd2,
        char_walk2     = 5'd3,
        char_walk3     = 5'd4,
        big_still      = 5'd5,
        big_jump       = 5'd6,
        big_walk1      = 5'd7,
        big_walk2      = 5'd8,
        big_walk3      = 5'd9,
        char_dead      = 5'd10,
        enemy_walk1    = 5'd11,
        enemy_walk2    = 5'd12,
        enemy_squished = 5'd13,
        tile_ground    = 5'd14,
        tile_dirt      = 5'd15,
        tile_pipe      = 5'd16,
        tile_brick     = 5'd17,
        none           = 5'd31
    } sprite_id_t;

    // whole word for the key compare, channels for the output
    typedef union packed {
        logic [3*`CM_CHAN_W-1:0] word;
        struct packed {
            logic [`CM_CHAN_W-1:0] red;
            logic [`CM_CHAN_W-1:0] green;
            logic [`CM_CHAN_W-1:0] blue;
        } chan;
    } pixel_color_u;

endpackage

/* source/sprite_lookup_if.sv */
// sprite lookup bus, one selected image and address through the colour pipeline
`timescale 1ns/1ps
`include "color_map_cfg.svh"

interface sprite_lookup_if;

    color_map_pkg::sprite_id_t   sprite;
    logic [`CM_ADDR_W-1:0]       addr;
    // transparency test applies to this image
    logic                        keyed;
    logic [`CM_X_W-1:0]          draw_x;
    color_map_pkg::pixel_color_u color;

    modport select (
        output sprite,
        output addr,
        output keyed,
        output draw_x
    );

    modport rom (
        input  sprite,
        input  addr,
        output color
    );

    modport resolve (
        input sprite,
        input addr,
        input keyed,
        input draw_x,
        input color
    );

endinterface

/* source/pixel_ctrl.sv */
// pixel control, four-phase req/ack handshake and per-stage load sequencing
`timescale 1ns/1ps

module pixel_ctrl (
    input  logic clk,
    input  logic arst_n,
    input  logic pix_req,
    output logic pix_ack,
    output logic sel_load,
    output logic rom_load,
    output logic out_load
);

    typedef enum logic [1:0] {
        st_idle,
        st_select,
        st_read,
        st_resolve
    } state_t;

    state_t state;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state <= st_idle;
        end
        else
        begin
            case (state)
                // a held ack means the last pixel is not yet released
                st_idle:    state <= (pix_req && !pix_ack) ? st_select : st_idle;
                st_select:  state <= st_read;
                st_read:    state <= st_resolve;
                default:    state <= st_idle;
            endcase
        end
    end

    // ack rises with the output registers, drops once req is seen low
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pix_ack <= 1'b0;
        end
        else
        begin
            pix_ack <= (state == st_resolve) || (pix_ack && pix_req);
        end
    end

    assign sel_load = (state == st_select);
    assign rom_load = (state == st_read);
    assign out_load = (state == st_resolve);

endmodule

/* source/layer_select.sv */
// layer select picks the visible layer and sprite frame and registers the lookup
`timescale 1ns/1ps
`include "color_map_cfg.svh"

module layer_select (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  sel_load,
    input  logic [`CM_X_W-1:0]    draw_x,
    input  logic                  is_char,
    input  logic [1:0]            char_health,
    input  logic                  char_on_ground,
    input  logic                  char_walking,
    input  logic [1:0]            char_walk_count,
    input  logic [9:0]            char_address,
    input  logic                  is_enemy,
    input  logic                  enemy_health,
    input  logic                  enemy_walk_count,
    input  logic [8:0]            enemy_address,
    input  logic                  is_barrier,
    input  logic                  is_brick,
    input  logic                  is_dirt,
    input  logic                  is_pipe,
    input  logic [`CM_ADDR_W-1:0] barrier_address,
    sprite_lookup_if.select       lookup
);

    color_map_pkg::sprite_id_t next_sprite;
    logic [`CM_ADDR_W-1:0]     next_addr;
    logic                      next_keyed;
    // offset from still within one character form
    logic [4:0]                char_frame;

    always_comb
    begin
        if (!char_on_ground)
            char_frame = 5'd1;
        else if (!char_walking)
            char_frame = 5'd0;
        else if (char_walk_count == 2'd1)
            char_frame = 5'd2;
        else if (char_walk_count == 2'd2)
            char_frame = 5'd3;
        else
            char_frame = 5'd4;
    end

    // character over enemy over barrier
    always_comb
    begin
        next_sprite = color_map_pkg::none;
        next_addr   = '0;
        if (is_char)
        begin
            next_addr = `CM_ADDR_W'(char_address);
            if (char_health == 2'd0)
                next_sprite = color_map_pkg::char_dead;
            else if (char_health == 2'd2)
                next_sprite = color_map_pkg::sprite_id_t'(color_map_pkg::big_still + char_frame);
            else
                next_sprite = color_map_pkg::sprite_id_t'(color_map_pkg::char_still + char_frame);
        end
        else if (is_enemy)
        begin
            next_addr = `CM_ADDR_W'(enemy_address);
            if (!enemy_health)
                next_sprite = color_map_pkg::enemy_squished;
            else if (!enemy_walk_count)
                next_sprite = color_map_pkg::enemy_walk1;
            else
                next_sprite = color_map_pkg::enemy_walk2;
        end
        else if (is_barrier)
        begin
            next_addr = barrier_address;
            case ({is_brick, is_dirt, is_pipe})
                3'b000:  next_sprite = color_map_pkg::tile_ground;
                3'b010:  next_sprite = color_map_pkg::tile_dirt;
                3'b001:  next_sprite = color_map_pkg::tile_pipe;
                default: next_sprite = color_map_pkg::tile_brick;
            endcase
        end
    end

    // solid tiles ignore the key colour
    assign next_keyed = !((next_sprite == color_map_pkg::tile_ground) ||
                          (next_sprite == color_map_pkg::tile_dirt) ||
                          (next_sprite == color_map_pkg::tile_brick));

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            lookup.sprite <= color_map_pkg::none;
            lookup.keyed  <= 1'b0;
        end
        else if (sel_load)
        begin
            lookup.sprite <= next_sprite;
            lookup.keyed  <= next_keyed;
        end
    end

    always_ff @(posedge clk)
    begin
        if (sel_load)
        begin
            lookup.addr   <= next_addr;
            lookup.draw_x <= draw_x;
        end
    end

endmodule

/* source/sprite_rom.sv */
// sprite image store generating each colour word from image number and address
`timescale 1ns/1ps
`include "color_map_cfg.svh"

module sprite_rom (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          rom_load,
    sprite_lookup_if.rom  lookup
);

    logic [4:0]                  s;
    logic [1:0]                  key_sum;
    color_map_pkg::pixel_color_u rom_word;

    assign s       = lookup.sprite;
    assign key_sum = lookup.addr[1:0] + s[1:0];

    always_comb
    begin
        if (key_sum == 2'd0)
        begin
            rom_word.word = `CM_KEY;
        end
        else
        begin
            // red is s * 16 plus the address nibble
            rom_word.chan.red   = {s[3:0], lookup.addr[3:0]};
            rom_word.chan.green = lookup.addr[7:0];
            rom_word.chan.blue  = 8'h40 + `CM_CHAN_W'(s);
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            lookup.color <= '0;
        else if (rom_load)
            lookup.color <= rom_word;
    end

endmodule

/* source/color_resolve.sv */
// colour resolve, transparency test against the key and the striped background
`timescale 1ns/1ps
`include "color_map_cfg.svh"

module color_resolve (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  out_load,
    sprite_lookup_if.resolve      lookup,
    output logic [`CM_CHAN_W-1:0] red,
    output logic [`CM_CHAN_W-1:0] green,
    output logic [`CM_CHAN_W-1:0] blue
);

    logic                  show_bg;
    logic [`CM_CHAN_W-1:0] bg_blue;

    assign show_bg = (lookup.sprite == color_map_pkg::none) ||
                     (lookup.keyed && (lookup.color.word == `CM_KEY));

    // blue fades every eight columns
    assign bg_blue = `CM_BG_BASE - `CM_CHAN_W'(lookup.draw_x >> 3);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end
        else if (out_load)
        begin
            if (show_bg)
            begin
                red   <= '0;
                green <= '0;
                blue  <= bg_blue;
            end
            else
            begin
                red   <= lookup.color.chan.red;
                green <= lookup.color.chan.green;
                blue  <= lookup.color.chan.blue;
            end
        end
    end

endmodule

/* source/color_mapper.sv */
// pixel colour mapper, three-stage lookup of one pixel per req/ack handshake
`timescale 1ns/1ps
`include "color_map_cfg.svh"

module color_mapper (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  pix_req,
    input  logic [`CM_X_W-1:0]    draw_x,
    input  logic                  is_char,
    input  logic [1:0]            char_health,
    input  logic                  char_on_ground,
    input  logic                  char_walking,
    input  logic [1:0]            char_walk_count,
    input  logic [9:0]            char_address,
    input  logic                  is_enemy,
    input  logic                  enemy_health,
    input  logic                  enemy_walk_count,
    input  logic [8:0]            enemy_address,
    input  logic                  is_barrier,
    input  logic                  is_brick,
    input  logic                  is_dirt,
    input  logic                  is_pipe,
    input  logic [`CM_ADDR_W-1:0] barrier_address,
    output logic                  pix_ack,
    output logic [`CM_CHAN_W-1:0] red,
    output logic [`CM_CHAN_W-1:0] green,
    output logic [`CM_CHAN_W-1:0] blue
);

    logic sel_load;
    logic rom_load;
    logic out_load;

    sprite_lookup_if lookup_bus ();

    pixel_ctrl u_ctrl (
        .clk      (clk),
        .arst_n   (arst_n),
        .pix_req  (pix_req),
        .pix_ack  (pix_ack),
        .sel_load (sel_load),
        .rom_load (rom_load),
        .out_load (out_load)
    );

    layer_select u_select (
        .clk              (clk),
        .arst_n           (arst_n),
        .sel_load         (sel_load),
        .draw_x           (draw_x),
        .is_char          (is_char),
        .char_health      (char_health),
        .char_on_ground   (char_on_ground),
        .char_walking     (char_walking),
        .char_walk_count  (char_walk_count),
        .char_address     (char_address),
        .is_enemy         (is_enemy),
        .enemy_health     (enemy_health),
        .enemy_walk_count (enemy_walk_count),
        .enemy_address    (enemy_address),
        .is_barrier       (is_barrier),
        .is_brick         (is_brick),
        .is_dirt          (is_dirt),
        .is_pipe          (is_pipe),
        .barrier_address  (barrier_address),
        .lookup           (lookup_bus.select)
    );

    sprite_rom u_rom (
        .clk      (clk),
        .arst_n   (arst_n),
        .rom_load (rom_load),
        .lookup   (lookup_bus.rom)
    );

    color_resolve u_resolve (
        .clk      (clk),
        .arst_n   (arst_n),
        .out_load (out_load),
        .lookup   (lookup_bus.resolve),
        .red      (red),
        .green    (green),
        .blue     (blue)
    );

endmodule

/* tests/color_checker.sv */
// colour checker, compares each newly acknowledged pixel with its expected colour
`timescale 1ns/1ps
`include "color_map_cfg.svh"

module color_checker (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  pix_ack,
    input  logic [`CM_CHAN_W-1:0] red,
    input  logic [`CM_CHAN_W-1:0] green,
    input  logic [`CM_CHAN_W-1:0] blue,
    input  logic [`CM_CHAN_W-1:0] expected_red,
    input  logic [`CM_CHAN_W-1:0] expected_green,
    input  logic [`CM_CHAN_W-1:0] expected_blue,
    output int                    errors,
    output int                    checks
);

    logic ack_seen;

    function automatic bit channel_matches(input string name,
                                           input logic [`CM_CHAN_W-1:0] got,
                                           input logic [`CM_CHAN_W-1:0] want);
        if (got !== want)
            $display("[FAIL] %s: got %h, expected %h", name, got, want);
        return (got === want);
    endfunction

    // falling edge, outputs settled since the last rising edge
    always @(negedge clk)
    begin
        if (!arst_n)
        begin
            ack_seen = 1'b0;
            errors   = 0;
            checks   = 0;
        end
        else
        begin
            if (pix_ack && !ack_seen)
            begin
                checks++;
                if (!channel_matches("red", red, expected_red))
                    errors++;
                if (!channel_matches("green", green, expected_green))
                    errors++;
                if (!channel_matches("blue", blue, expected_blue))
                    errors++;
            end
            ack_seen = pix_ack;
        end
    end

endmodule

/* tests/color_mapper_asserts.sv */
// handshake and colour stability assertions for the colour mapper
`timescale 1ns/1ps
`include "color_map_cfg.svh"

module color_mapper_asserts (
    input logic                  clk,
    input logic                  arst_n,
    input logic                  pix_req,
    input logic                  pix_ack,
    input logic [`CM_CHAN_W-1:0] red,
    input logic [`CM_CHAN_W-1:0] green,
    input logic [`CM_CHAN_W-1:0] blue
);

    int fail_count = 0;

    ack_in_reset: assert property (@(posedge clk) !arst_n |-> !pix_ack)
        else
        begin
            fail_count++;
            $error("ack high while reset is asserted");
        end

    ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(pix_ack) |-> $past(pix_req))
        else
        begin
            fail_count++;
            $error("ack rose without a pending req");
        end

    color_held: assert property (@(posedge clk) disable iff (!arst_n)
        pix_ack && $past(pix_ack) |-> $stable({red, green, blue}))
        else
        begin
            fail_count++;
            $error("colour changed while ack was high");
        end

    // the rise is seen one edge after the edge that sets ack
    ack_latency: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(pix_ack) |-> $past(pix_req, `CM_RESOLVE_LAT + 1) &&
                           !$past(pix_req, `CM_RESOLVE_LAT + 2))
        else
        begin
            fail_count++;
            $error("ack did not rise the expected number of edges after req");
        end

endmodule

bind color_mapper color_mapper_asserts u_asserts (
    .clk     (clk),
    .arst_n  (arst_n),
    .pix_req (pix_req),
    .pix_ack (pix_ack),
    .red     (red),
    .green   (green),
    .blue    (blue)
);

/* tests/tb_color_mapper.sv */
// colour mapper testbench, trace-driven pixel requests over the req/ack handshake
`timescale 1ns/1ps
`include "color_map_cfg.svh"

module tb_color_mapper;

    localparam int ACK_TIMEOUT = 64;

    logic                  clk;
    logic                  arst_n;
    logic                  pix_req;
    logic [`CM_X_W-1:0]    draw_x;
    logic                  is_char;
    logic [1:0]            char_health;
    logic                  char_on_ground;
    logic                  char_walking;
    logic [1:0]            char_walk_count;
    logic [9:0]            char_address;
    logic                  is_enemy;
    logic                  enemy_health;
    logic                  enemy_walk_count;
    logic [8:0]            enemy_address;
    logic                  is_barrier;
    logic                  is_brick;
    logic                  is_dirt;
    logic                  is_pipe;
    logic [`CM_ADDR_W-1:0] barrier_address;
    logic                  pix_ack;
    logic [`CM_CHAN_W-1:0] red;
    logic [`CM_CHAN_W-1:0] green;
    logic [`CM_CHAN_W-1:0] blue;
    logic [`CM_CHAN_W-1:0] expected_red;
    logic [`CM_CHAN_W-1:0] expected_green;
    logic [`CM_CHAN_W-1:0] expected_blue;

    // fields of the current trace line
    logic [`CM_X_W-1:0]    tr_draw_x;
    logic                  tr_is_char;
    logic [1:0]            tr_char_health;
    logic                  tr_char_on_ground;
    logic                  tr_char_walking;
    logic [1:0]            tr_char_walk_count;
    logic [9:0]            tr_char_address;
    logic                  tr_is_enemy;
    logic                  tr_enemy_health;
    logic                  tr_enemy_walk_count;
    logic [8:0]            tr_enemy_address;
    logic                  tr_is_barrier;
    logic                  tr_is_brick;
    logic                  tr_is_dirt;
    logic                  tr_is_pipe;
    logic [`CM_ADDR_W-1:0] tr_barrier_address;
    logic [`CM_CHAN_W-1:0] tr_red;
    logic [`CM_CHAN_W-1:0] tr_green;
    logic [`CM_CHAN_W-1:0] tr_blue;
    int                    tr_hold;

    int check_errors;
    int checks_done;
    int timeouts;
    int trace_errors;
    int requests;

    color_mapper u_dut (
        .clk              (clk),
        .arst_n           (arst_n),
        .pix_req          (pix_req),
        .draw_x           (draw_x),
        .is_char          (is_char),
        .char_health      (char_health),
        .char_on_ground   (char_on_ground),
        .char_walking     (char_walking),
        .char_walk_count  (char_walk_count),
        .char_address     (char_address),
        .is_enemy         (is_enemy),
        .enemy_health     (enemy_health),
        .enemy_walk_count (enemy_walk_count),
        .enemy_address    (enemy_address),
        .is_barrier       (is_barrier),
        .is_brick         (is_brick),
        .is_dirt          (is_dirt),
        .is_pipe          (is_pipe),
        .barrier_address  (barrier_address),
        .pix_ack          (pix_ack),
        .red              (red),
        .green            (green),
        .blue             (blue)
    );

    color_checker u_checker (
        .clk            (clk),
        .arst_n         (arst_n),
        .pix_ack        (pix_ack),
        .red            (red),
        .green          (green),
        .blue           (blue),
        .expected_red   (expected_red),
        .expected_green (expected_green),
        .expected_blue  (expected_blue),
        .errors         (check_errors),
        .checks         (checks_done)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #4 clk = ~clk;
    end

    // ack value as seen at the last rising edge
    task automatic wait_for_ack(input logic level, output bit ok);
        int cycles;
        cycles = 0;
        while (pix_ack !== level && cycles < ACK_TIMEOUT)
        begin
            @(posedge clk);
            cycles++;
        end
        ok = (pix_ack === level);
    endtask

    task automatic request_pixel();
        bit ok;
        @(posedge clk);
        draw_x           <= tr_draw_x;
        is_char          <= tr_is_char;
        char_health      <= tr_char_health;
        char_on_ground   <= tr_char_on_ground;
        char_walking     <= tr_char_walking;
        char_walk_count  <= tr_char_walk_count;
        char_address     <= tr_char_address;
        is_enemy         <= tr_is_enemy;
        enemy_health     <= tr_enemy_health;
        enemy_walk_count <= tr_enemy_walk_count;
        enemy_address    <= tr_enemy_address;
        is_barrier       <= tr_is_barrier;
        is_brick         <= tr_is_brick;
        is_dirt          <= tr_is_dirt;
        is_pipe          <= tr_is_pipe;
        barrier_address  <= tr_barrier_address;
        expected_red     <= tr_red;
        expected_green   <= tr_green;
        expected_blue    <= tr_blue;
        pix_req          <= 1'b1;
        requests++;
        wait_for_ack(1'b1, ok);
        if (!ok)
        begin
            $display("no ack within %0d cycles for request %0d", ACK_TIMEOUT, requests);
            timeouts++;
            return;
        end
        // a held req keeps ack and colour frozen
        repeat (tr_hold) @(posedge clk);
        pix_req <= 1'b0;
        wait_for_ack(1'b0, ok);
        if (!ok)
        begin
            $display("ack still high %0d cycles after req %0d was dropped",
                     ACK_TIMEOUT, requests);
            timeouts++;
        end
    endtask

    task automatic report_and_finish();
        int assert_fails;
        int missing;
        assert_fails = u_dut.u_asserts.fail_count;
        missing = requests - checks_done;
        if (missing != 0)
            $display("%0d of %0d requests got no new colour", missing, requests);
        $display("errors: %0d colour, %0d assertion, %0d trace; timeouts: %0d; checked: %0d",
                 check_errors, assert_fails, trace_errors, timeouts, checks_done);
        if (check_errors == 0 && assert_fails == 0 && trace_errors == 0 &&
            timeouts == 0 && missing == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    endtask

    initial
    begin
        int    fd;
        int    n;
        int    line_no;
        string line;

        arst_n           = 1'b0;
        pix_req          = 1'b0;
        draw_x           = '0;
        is_char          = 1'b0;
        char_health      = '0;
        char_on_ground   = 1'b0;
        char_walking     = 1'b0;
        char_walk_count  = '0;
        char_address     = '0;
        is_enemy         = 1'b0;
        enemy_health     = 1'b0;
        enemy_walk_count = 1'b0;
        enemy_address    = '0;
        is_barrier       = 1'b0;
        is_brick         = 1'b0;
        is_dirt          = 1'b0;
        is_pipe          = 1'b0;
        barrier_address  = '0;
        expected_red     = '0;
        expected_green   = '0;
        expected_blue    = '0;
        timeouts         = 0;
        trace_errors     = 0;
        requests         = 0;
        line_no          = 0;

        repeat (8) @(posedge clk);
        arst_n <= 1'b1;

        fd = $fopen("tests/color_trace.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open the trace file tests/color_trace.txt");
            trace_errors++;
        end
        else
        begin
            while (timeouts == 0 && $fgets(line, fd) != 0)
            begin
                line_no++;
                // skip column notes and blank lines
                if (line.len() > 1 && line.getc(0) != "#")
                begin
                    n = $sscanf(line,
                        "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        tr_draw_x, tr_is_char, tr_char_health, tr_char_on_ground,
                        tr_char_walking, tr_char_walk_count, tr_char_address,
                        tr_is_enemy, tr_enemy_health, tr_enemy_walk_count,
                        tr_enemy_address, tr_is_barrier, tr_is_brick, tr_is_dirt,
                        tr_is_pipe, tr_barrier_address, tr_red, tr_green, tr_blue,
                        tr_hold);
                    if (n != 20)
                    begin
                        $display("trace line %0d has %0d fields instead of 20", line_no, n);
                        trace_errors++;
                    end
                    else
                        request_pixel();
                end
            end
            $fclose(fd);
        end
        report_and_finish();
    end

endmodule

/* tests/color_trace.txt */
# draw_x char c_health on_ground walking walk_cnt c_addr enemy e_health e_walk e_addr
# barrier brick dirt pipe b_addr | expected red green blue | extra req hold cycles
010 1 1 1 0 0 035 0 0 0 000 0 0 0 0 000 05 35 40 0
020 1 3 0 1 2 122 0 0 0 000 0 0 0 0 000 12 22 41 0
030 1 1 1 1 1 2a7 0 0 0 000 0 0 0 0 000 27 a7 42 0
040 1 3 1 1 2 0ca 0 0 0 000 0 0 0 0 000 3a ca 43 0
050 1 1 1 1 3 3f1 0 0 0 000 0 0 0 0 000 41 f1 44 0
060 1 1 1 1 0 015 0 0 0 000 0 0 0 0 000 45 15 44 0
070 1 2 1 0 3 1b6 0 0 0 000 0 0 0 0 000 56 b6 45 0
080 1 2 0 0 0 200 0 0 0 000 0 0 0 0 000 60 00 46 0
090 1 2 1 1 1 08e 0 0 0 000 0 0 0 0 000 7e 8e 47 0
0a0 1 2 1 1 2 333 0 0 0 000 0 0 0 0 000 83 33 48 9
0b0 1 2 1 1 3 154 0 0 0 000 0 0 0 0 000 94 54 49 0
0c0 1 0 0 1 1 3c5 0 0 0 000 0 0 0 0 000 a5 c5 4a 0
0d0 1 0 1 1 2 007 0 0 0 000 0 0 0 0 000 a7 07 4a 0
0e0 0 0 0 0 0 000 1 0 1 1e2 0 0 0 0 000 d2 e2 4d 0
0f0 0 0 0 0 0 000 1 1 0 0aa 0 0 0 0 000 ba aa 4b 0
100 0 0 0 0 0 000 1 1 1 17f 0 0 0 0 000 cf 7f 4c 0
110 0 0 0 0 0 000 0 0 0 000 1 0 0 0 402 00 ff cc 0
120 0 0 0 0 0 000 0 0 0 000 1 0 1 0 611 00 ff cc 0
130 0 0 0 0 0 000 0 0 0 000 1 0 0 1 5a1 01 a1 50 0
140 0 0 0 0 0 000 0 0 0 000 1 1 0 0 7ff 00 ff cc 0
150 0 0 0 0 0 000 0 0 0 000 1 0 1 1 024 14 24 51 0
160 0 0 0 0 0 000 0 0 0 000 1 1 1 1 0e6 16 e6 51 0
170 0 0 0 0 0 000 0 0 0 000 1 1 1 0 3b9 19 b9 51 0
180 0 0 0 0 0 000 0 0 0 000 1 1 0 1 052 12 52 51 0
0a5 1 1 1 0 0 084 0 0 0 000 0 0 0 0 000 00 00 6b 0
3ff 0 0 0 0 0 000 1 1 0 0a9 0 0 0 0 000 00 00 00 0
000 0 0 0 0 0 000 0 0 0 000 1 0 0 1 2c8 00 00 7f 0
155 1 2 0 0 0 20a 0 0 0 000 0 0 0 0 000 00 00 55 0
1f0 0 3 1 1 3 3ff 0 1 1 1ff 0 1 1 1 7ff 00 00 41 0
1c8 1 1 1 0 0 0f2 1 1 1 17f 1 0 0 1 5a1 02 f2 40 0
1d0 0 0 0 0 0 000 1 0 0 101 1 1 0 0 7ff d1 01 4d 6

/* all.f */
+incdir+source
source/color_map_pkg.sv
source/sprite_lookup_if.sv
source/pixel_ctrl.sv
source/layer_select.sv
source/sprite_rom.sv
source/color_resolve.sv
source/color_mapper.sv
tests/color_checker.sv
tests/color_mapper_asserts.sv
tests/tb_color_mapper.sv

/* Makefile */
# Verilator build and run of the colour mapper testbench

.PHONY: run clean

run: obj_dir/Vtb_color_mapper
	./obj_dir/Vtb_color_mapper +verilator+error+limit+100 2>&1 | tee sim.log
	grep -q "Verification passed" sim.log

obj_dir/Vtb_color_mapper: all.f $(wildcard source/*.sv source/*.svh tests/*.sv)
	verilator --binary --assert --timing --timescale 1ns/1ps \
		--top-module tb_color_mapper -f all.f

clean:
	rm -rf obj_dir sim.log
